//--- source/idu_pkg.sv
`default_nettype none

package idu_pkg;

    typedef logic [4:0] reg_addr_t;

    // Opcodes are prefixed so they do not collide with the instruction numbers
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_e;

    // Format n marks a word that has no valid format
    typedef enum logic [2:0] {
        n = 3'd0,
        r = 3'd1,
        i = 3'd2,
        s = 3'd3,
        b = 3'd4,
        u = 3'd5,
        j = 3'd6
    } inst_type_e;

    typedef enum logic [5:0] {
        inv,
        lui, auipc, jal, jalr,
        beq, bne, blt, bge, bltu, bgeu,
        lb, lh, lw, lbu, lhu,
        sb, sh, sw,
        addi, slti, sltiu, xori, ori, andi, slli, srli, srai,
        add, sub, sll, slt, sltu, xor_i, srl, sra, or_i, and_i,
        ecall, ebreak
    } inst_num_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One instruction word, seen through the layout of each format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_word_t;

    typedef struct packed {
        inst_num_e branch_num;
        inst_num_e load_num;
        inst_num_e store_num;
        inst_num_e op_imm_num;
        inst_num_e op_num;
        inst_num_e system_num;
    } funct_nums_t;

    typedef struct packed {
        inst_num_e   inst_num;
        inst_type_e  inst_type;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [31:0] imm;
    } decoded_t;

endpackage

`default_nettype wire

//--- source/idu_funct_decode.sv
`timescale 1ns/1ps
`default_nettype none

module idu_funct_decode (
    input  idu_pkg::inst_word_t  inst,
    output idu_pkg::funct_nums_t funct_nums
);

    localparam logic [6:0] funct7_base = 7'h00;
    localparam logic [6:0] funct7_alt  = 7'h20;

    always_comb begin
        funct_nums = '0;

        // Conditional branches leave funct3 values 2 and 3 unused
        case (inst.b.funct3)
            3'd0:    funct_nums.branch_num = idu_pkg::beq;
            3'd1:    funct_nums.branch_num = idu_pkg::bne;
            3'd4:    funct_nums.branch_num = idu_pkg::blt;
            3'd5:    funct_nums.branch_num = idu_pkg::bge;
            3'd6:    funct_nums.branch_num = idu_pkg::bltu;
            3'd7:    funct_nums.branch_num = idu_pkg::bgeu;
            default: funct_nums.branch_num = idu_pkg::inv;
        endcase

        case (inst.i.funct3)
            3'd0:    funct_nums.load_num = idu_pkg::lb;
            3'd1:    funct_nums.load_num = idu_pkg::lh;
            3'd2:    funct_nums.load_num = idu_pkg::lw;
            3'd4:    funct_nums.load_num = idu_pkg::lbu;
            3'd5:    funct_nums.load_num = idu_pkg::lhu;
            default: funct_nums.load_num = idu_pkg::inv;
        endcase

        case (inst.s.funct3)
            3'd0:    funct_nums.store_num = idu_pkg::sb;
            3'd1:    funct_nums.store_num = idu_pkg::sh;
            3'd2:    funct_nums.store_num = idu_pkg::sw;
            default: funct_nums.store_num = idu_pkg::inv;
        endcase

        // Shift immediates keep their funct7 in the top of the imm field
        case (inst.i.funct3)
            3'd0: funct_nums.op_imm_num = idu_pkg::addi;
            3'd2: funct_nums.op_imm_num = idu_pkg::slti;
            3'd3: funct_nums.op_imm_num = idu_pkg::sltiu;
            3'd4: funct_nums.op_imm_num = idu_pkg::xori;
            3'd6: funct_nums.op_imm_num = idu_pkg::ori;
            3'd7: funct_nums.op_imm_num = idu_pkg::andi;
            3'd1: begin
                if (inst.r.funct7 == funct7_base) begin
                    funct_nums.op_imm_num = idu_pkg::slli;
                end else begin
                    funct_nums.op_imm_num = idu_pkg::inv;
                end
            end
            default: begin
                if (inst.r.funct7 == funct7_base) begin
                    funct_nums.op_imm_num = idu_pkg::srli;
                end else if (inst.r.funct7 == funct7_alt) begin
                    funct_nums.op_imm_num = idu_pkg::srai;
                end else begin
                    funct_nums.op_imm_num = idu_pkg::inv;
                end
            end
        endcase

        // Register ops use funct7 0 for the base op and 0x20 for sub and sra
        if (inst.r.funct7 == funct7_base) begin
            case (inst.r.funct3)
                3'd0:    funct_nums.op_num = idu_pkg::add;
                3'd1:    funct_nums.op_num = idu_pkg::sll;
                3'd2:    funct_nums.op_num = idu_pkg::slt;
                3'd3:    funct_nums.op_num = idu_pkg::sltu;
                3'd4:    funct_nums.op_num = idu_pkg::xor_i;
                3'd5:    funct_nums.op_num = idu_pkg::srl;
                3'd6:    funct_nums.op_num = idu_pkg::or_i;
                default: funct_nums.op_num = idu_pkg::and_i;
            endcase
        end else if (inst.r.funct7 == funct7_alt) begin
            case (inst.r.funct3)
                3'd0:    funct_nums.op_num = idu_pkg::sub;
                3'd5:    funct_nums.op_num = idu_pkg::sra;
                default: funct_nums.op_num = idu_pkg::inv;
            endcase
        end else begin
            funct_nums.op_num = idu_pkg::inv;
        end

        // Only ecall and ebreak are decoded and every other system encoding is invalid
        if (inst.i.funct3 == 3'd0 && inst.i.rs1 == 5'd0 && inst.i.rd == 5'd0) begin
            case (inst.i.imm_11_0)
                12'h000: funct_nums.system_num = idu_pkg::ecall;
                12'h001: funct_nums.system_num = idu_pkg::ebreak;
                default: funct_nums.system_num = idu_pkg::inv;
            endcase
        end else begin
            funct_nums.system_num = idu_pkg::inv;
        end
    end

endmodule

`default_nettype wire

//--- source/idu_opcode.sv
`timescale 1ns/1ps
`default_nettype none

module idu_opcode (
    input  idu_pkg::inst_word_t  inst,
    input  idu_pkg::funct_nums_t funct_nums,
    output idu_pkg::decoded_t    decoded
);

    idu_pkg::inst_num_e  num;
    idu_pkg::inst_type_e fmt;
    logic [31:0]         imm;

    always_comb begin
        case (inst.r.opcode)
            idu_pkg::opc_lui:    num = idu_pkg::lui;
            idu_pkg::opc_auipc:  num = idu_pkg::auipc;
            idu_pkg::opc_jal:    num = idu_pkg::jal;
            idu_pkg::opc_jalr: begin
                if (inst.i.funct3 == 3'd0) begin
                    num = idu_pkg::jalr;
                end else begin
                    num = idu_pkg::inv;
                end
            end
            idu_pkg::opc_branch: num = funct_nums.branch_num;
            idu_pkg::opc_load:   num = funct_nums.load_num;
            idu_pkg::opc_store:  num = funct_nums.store_num;
            idu_pkg::opc_op_imm: num = funct_nums.op_imm_num;
            idu_pkg::opc_op:     num = funct_nums.op_num;
            idu_pkg::opc_system: num = funct_nums.system_num;
            default:             num = idu_pkg::inv;
        endcase
    end

    always_comb begin
        case (inst.r.opcode)
            idu_pkg::opc_lui,
            idu_pkg::opc_auipc:  fmt = idu_pkg::u;
            idu_pkg::opc_jal:    fmt = idu_pkg::j;
            idu_pkg::opc_jalr,
            idu_pkg::opc_load,
            idu_pkg::opc_op_imm,
            idu_pkg::opc_system: fmt = idu_pkg::i;
            idu_pkg::opc_branch: fmt = idu_pkg::b;
            idu_pkg::opc_store:  fmt = idu_pkg::s;
            idu_pkg::opc_op:     fmt = idu_pkg::r;
            default:             fmt = idu_pkg::n;
        endcase
    end

    // Bit 31 of the word is the sign bit for every format
    always_comb begin
        case (fmt)
            idu_pkg::i: begin
                imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            end
            idu_pkg::s: begin
                imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            end
            idu_pkg::b: begin
                imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            end
            idu_pkg::u: begin
                imm = {inst.u.imm_31_12, 12'h000};
            end
            idu_pkg::j: begin
                imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            end
            default: begin
                imm = 32'h0;
            end
        endcase
    end

    // An invalid instruction carries no format and no immediate
    always_comb begin
        decoded.inst_num = num;
        decoded.rd       = inst.r.rd;
        decoded.rs1      = inst.r.rs1;
        decoded.rs2      = inst.r.rs2;
        if (num == idu_pkg::inv) begin
            decoded.inst_type = idu_pkg::n;
            decoded.imm       = 32'h0;
        end else begin
            decoded.inst_type = fmt;
            decoded.imm       = imm;
        end
    end

endmodule

`default_nettype wire

//--- source/idu.sv
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  idu_pkg::inst_word_t inst,
    output logic                out_valid,
    output idu_pkg::decoded_t   decoded
);

    idu_pkg::funct_nums_t funct_nums;
    idu_pkg::decoded_t    next_decoded;

    idu_funct_decode u_funct_decode (
        .inst       (inst),
        .funct_nums (funct_nums)
    );

    idu_opcode u_opcode (
        .inst       (inst),
        .funct_nums (funct_nums),
        .decoded    (next_decoded)
    );

    // The decoded record holds its last value while no instruction arrives
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            decoded   <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                decoded <= next_decoded;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/idu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module idu_tb;

    localparam int n_valid_words   = 62;
    localparam int n_imm_words     = 20;
    localparam int n_invalid_words = 17;
    localparam int stream_len      = 200;
    localparam int gap_len         = 120;
    // A lone word takes two cycles and a streamed word takes one
    localparam int test_cycles = 12 + 2 * (n_valid_words + n_imm_words + n_invalid_words)
                                 + stream_len + gap_len + 4;

    // The ten handled opcodes are packed seven bits apiece
    localparam logic [69:0] valid_opcodes = {
        7'b1110011, 7'b0110011, 7'b0010011, 7'b0100011, 7'b0000011,
        7'b1100011, 7'b1100111, 7'b1101111, 7'b0010111, 7'b0110111
    };
    localparam logic [127:0] imm_patterns = {
        32'h7FFFFFFF, 32'hFFFFFFFF, 32'h55555555, 32'hAAAAAAAA
    };
    // Formats I, S, B, U and J in that order
    localparam logic [34:0] imm_opcodes = {
        7'b1101111, 7'b0110111, 7'b1100011, 7'b0100011, 7'b0010011
    };

    logic                clk = 1'b0;
    logic                arst_n;
    logic                in_valid;
    idu_pkg::inst_word_t inst;
    logic                out_valid;
    idu_pkg::decoded_t   decoded;

    int                  errors = 0;
    integer              seed = 21218;
    idu_pkg::decoded_t   last_exp = '0;

    idu u_idu (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .inst      (inst),
        .out_valid (out_valid),
        .decoded   (decoded)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] enc(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic idu_pkg::inst_num_e expected_num(logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            7'b0110111: return idu_pkg::lui;
            7'b0010111: return idu_pkg::auipc;
            7'b1101111: return idu_pkg::jal;
            7'b1100111: if (f3 == 3'd0) return idu_pkg::jalr;
            7'b1100011: begin
                case (f3)
                    3'd0: return idu_pkg::beq;
                    3'd1: return idu_pkg::bne;
                    3'd4: return idu_pkg::blt;
                    3'd5: return idu_pkg::bge;
                    3'd6: return idu_pkg::bltu;
                    3'd7: return idu_pkg::bgeu;
                    default: ;
                endcase
            end
            7'b0000011: begin
                case (f3)
                    3'd0: return idu_pkg::lb;
                    3'd1: return idu_pkg::lh;
                    3'd2: return idu_pkg::lw;
                    3'd4: return idu_pkg::lbu;
                    3'd5: return idu_pkg::lhu;
                    default: ;
                endcase
            end
            7'b0100011: begin
                if (f3 == 3'd0) return idu_pkg::sb;
                if (f3 == 3'd1) return idu_pkg::sh;
                if (f3 == 3'd2) return idu_pkg::sw;
            end
            7'b0010011: begin
                case (f3)
                    3'd0: return idu_pkg::addi;
                    3'd2: return idu_pkg::slti;
                    3'd3: return idu_pkg::sltiu;
                    3'd4: return idu_pkg::xori;
                    3'd6: return idu_pkg::ori;
                    3'd7: return idu_pkg::andi;
                    3'd1: if (f7 == 7'h00) return idu_pkg::slli;
                    default: begin
                        if (f7 == 7'h00) return idu_pkg::srli;
                        if (f7 == 7'h20) return idu_pkg::srai;
                    end
                endcase
            end
            7'b0110011: begin
                case ({f7, f3})
                    {7'h00, 3'd0}: return idu_pkg::add;
                    {7'h20, 3'd0}: return idu_pkg::sub;
                    {7'h00, 3'd1}: return idu_pkg::sll;
                    {7'h00, 3'd2}: return idu_pkg::slt;
                    {7'h00, 3'd3}: return idu_pkg::sltu;
                    {7'h00, 3'd4}: return idu_pkg::xor_i;
                    {7'h00, 3'd5}: return idu_pkg::srl;
                    {7'h20, 3'd5}: return idu_pkg::sra;
                    {7'h00, 3'd6}: return idu_pkg::or_i;
                    {7'h00, 3'd7}: return idu_pkg::and_i;
                    default: ;
                endcase
            end
            7'b1110011: begin
                if (f3 == 3'd0 && w[19:15] == 5'd0 && w[11:7] == 5'd0) begin
                    if (w[31:20] == 12'h000) return idu_pkg::ecall;
                    if (w[31:20] == 12'h001) return idu_pkg::ebreak;
                end
            end
            default: ;
        endcase
        return idu_pkg::inv;
    endfunction

    function automatic idu_pkg::decoded_t ref_decode(logic [31:0] w);
        idu_pkg::decoded_t d;
        d          = '0;
        d.inst_num = expected_num(w);
        d.rd       = w[11:7];
        d.rs1      = w[19:15];
        d.rs2      = w[24:20];
        case (w[6:0])
            7'b0110111, 7'b0010111: begin
                d.inst_type = idu_pkg::u;
                d.imm       = {w[31:12], 12'h000};
            end
            7'b1101111: begin
                d.inst_type = idu_pkg::j;
                d.imm       = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100111, 7'b0000011, 7'b0010011, 7'b1110011: begin
                d.inst_type = idu_pkg::i;
                d.imm       = {{20{w[31]}}, w[31:20]};
            end
            7'b1100011: begin
                d.inst_type = idu_pkg::b;
                d.imm       = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'b0100011: begin
                d.inst_type = idu_pkg::s;
                d.imm       = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            7'b0110011: d.inst_type = idu_pkg::r;
            default: ;
        endcase
        if (d.inst_num == idu_pkg::inv) begin
            d.inst_type = idu_pkg::n;
            d.imm       = 32'h0;
        end
        return d;
    endfunction

    function automatic idu_pkg::decoded_t inv_record(logic [31:0] w);
        idu_pkg::decoded_t d;
        d     = '0;
        d.rd  = w[11:7];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        return d;
    endfunction

    task automatic report_mismatch(string what, string field, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("MISMATCH at %0t: %s %s got 0x%0h expected 0x%0h", $time, what, field, got, exp);
    endtask

    task automatic check_decoded(idu_pkg::decoded_t got, idu_pkg::decoded_t exp, string what);
        if (got.inst_num !== exp.inst_num) begin
            report_mismatch(what, "inst_num", 32'(got.inst_num), 32'(exp.inst_num));
        end
        if (got.inst_type !== exp.inst_type) begin
            report_mismatch(what, "inst_type", 32'(got.inst_type), 32'(exp.inst_type));
        end
        if (got.rd !== exp.rd) report_mismatch(what, "rd", 32'(got.rd), 32'(exp.rd));
        if (got.rs1 !== exp.rs1) report_mismatch(what, "rs1", 32'(got.rs1), 32'(exp.rs1));
        if (got.rs2 !== exp.rs2) report_mismatch(what, "rs2", 32'(got.rs2), 32'(exp.rs2));
        if (got.imm !== exp.imm) report_mismatch(what, "imm", got.imm, exp.imm);
    endtask

    task automatic check_valid(logic got, logic exp, string what);
        if (got !== exp) report_mismatch(what, "out_valid", 32'(got), 32'(exp));
    endtask

    // Sends one word alone and checks the record one cycle later
    task automatic decode_one(logic [31:0] w, idu_pkg::decoded_t exp, string what);
        @(posedge clk);
        in_valid <= 1'b1;
        inst     <= w;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_valid(out_valid, 1'b1, what);
        check_decoded(decoded, exp, what);
        last_exp = exp;
    endtask

    task automatic reset_checks();
        repeat (8) begin
            @(negedge clk);
            check_valid(out_valid, 1'b0, "reset");
            check_decoded(decoded, '0, "reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_valid(out_valid, 1'b0, "after reset");
            check_decoded(decoded, '0, "after reset");
        end
    endtask

    // Every funct3 of each family is sent so that each defined number shows up at least once
    task automatic all_valid_numbers();
        logic [31:0] words [$];
        for (int k = 0; k < 8; k++) begin
            words.push_back(enc(7'h5a, 5'd7, 5'd9, 3'(k), 5'd11, 7'b1100011));
            words.push_back(enc(7'h15, 5'd12, 5'd13, 3'(k), 5'd14, 7'b0000011));
            words.push_back(enc(7'h33, 5'd15, 5'd16, 3'(k), 5'd17, 7'b0100011));
            words.push_back(enc(7'h00, 5'd18, 5'd19, 3'(k), 5'd20, 7'b0010011));
            words.push_back(enc(7'h20, 5'd21, 5'd22, 3'(k), 5'd23, 7'b0010011));
            words.push_back(enc(7'h00, 5'd24, 5'd25, 3'(k), 5'd26, 7'b0110011));
            words.push_back(enc(7'h20, 5'd27, 5'd28, 3'(k), 5'd29, 7'b0110011));
        end
        words.push_back(enc(7'h4d, 5'd3, 5'd5, 3'd6, 5'd1, 7'b0110111));
        words.push_back(enc(7'h2b, 5'd8, 5'd10, 3'd3, 5'd2, 7'b0010111));
        words.push_back(enc(7'h61, 5'd19, 5'd4, 3'd5, 5'd31, 7'b1101111));
        words.push_back(enc(7'h7f, 5'd30, 5'd2, 3'd0, 5'd1, 7'b1100111));
        words.push_back(32'h00000073);
        words.push_back(32'h00100073);
        foreach (words[k]) begin
            decode_one(words[k], ref_decode(words[k]), $sformatf("valid word 0x%h", words[k]));
        end
    endtask

    task automatic immediate_formats();
        logic [31:0] w;
        for (int p = 0; p < 4; p++) begin
            for (int f = 0; f < 5; f++) begin
                w      = imm_patterns[32 * p +: 32];
                w[6:0] = imm_opcodes[7 * f +: 7];
                if (f < 3) w[14:12] = 3'd0;
                decode_one(w, ref_decode(w), $sformatf("immediate word 0x%h", w));
            end
        end
    endtask

    task automatic invalid_encodings();
        logic [31:0] words [$];
        words.push_back(enc(7'h00, 5'd1, 5'd2, 3'd0, 5'd3, 7'b1111111));
        words.push_back(enc(7'h12, 5'd4, 5'd5, 3'd1, 5'd6, 7'b0000000));
        words.push_back(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 7'b0001111));
        words.push_back(enc(7'h01, 5'd4, 5'd5, 3'd2, 5'd6, 7'b1100011));
        words.push_back(enc(7'h7f, 5'd7, 5'd8, 3'd3, 5'd9, 7'b1100011));
        words.push_back(enc(7'h00, 5'd1, 5'd2, 3'd3, 5'd3, 7'b0000011));
        words.push_back(enc(7'h40, 5'd1, 5'd2, 3'd6, 5'd3, 7'b0000011));
        words.push_back(enc(7'h05, 5'd6, 5'd7, 3'd4, 5'd8, 7'b0100011));
        words.push_back(enc(7'h01, 5'd9, 5'd10, 3'd0, 5'd11, 7'b0110011));
        words.push_back(enc(7'h20, 5'd9, 5'd10, 3'd1, 5'd11, 7'b0110011));
        words.push_back(enc(7'h20, 5'd3, 5'd12, 3'd1, 5'd13, 7'b0010011));
        words.push_back(enc(7'h01, 5'd3, 5'd12, 3'd5, 5'd13, 7'b0010011));
        words.push_back(enc(7'h00, 5'd0, 5'd1, 3'd1, 5'd2, 7'b1100111));
        words.push_back(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd1, 7'b1110011));
        words.push_back(enc(7'h00, 5'd0, 5'd1, 3'd0, 5'd0, 7'b1110011));
        words.push_back(enc(7'h00, 5'd0, 5'd0, 3'd1, 5'd0, 7'b1110011));
        words.push_back(enc(7'h00, 5'd2, 5'd0, 3'd0, 5'd0, 7'b1110011));
        foreach (words[k]) begin
            decode_one(words[k], inv_record(words[k]), $sformatf("invalid word 0x%h", words[k]));
        end
    endtask

    // Each output of the back to back stream is checked against the word of the cycle before
    task automatic streaming();
        logic [31:0] words [stream_len];
        for (int k = 0; k < stream_len; k++) begin
            words[k] = $random(seed);
            if (k % 2 == 1) words[k][6:0] = valid_opcodes[7 * ({$random(seed)} % 10) +: 7];
            @(posedge clk);
            in_valid <= 1'b1;
            inst     <= words[k];
            @(negedge clk);
            if (k > 0) begin
                check_valid(out_valid, 1'b1, "stream");
                check_decoded(decoded, ref_decode(words[k - 1]), "stream");
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        last_exp = ref_decode(words[stream_len - 1]);
        check_valid(out_valid, 1'b1, "stream end");
        check_decoded(decoded, last_exp, "stream end");
    endtask

    task automatic valid_gaps();
        logic              v;
        logic              prev_v;
        logic [31:0]       w;
        logic [31:0]       prev_w;
        idu_pkg::decoded_t held;
        prev_v = 1'b0;
        prev_w = '0;
        held   = last_exp;
        for (int k = 0; k < gap_len; k++) begin
            v      = ($random(seed) % 3) != 0;
            w      = $random(seed);
            w[6:0] = valid_opcodes[7 * ({$random(seed)} % 10) +: 7];
            @(posedge clk);
            in_valid <= v;
            inst     <= w;
            @(negedge clk);
            if (prev_v) held = ref_decode(prev_w);
            check_valid(out_valid, prev_v, "gap");
            check_decoded(decoded, held, "gap");
            prev_v = v;
            prev_w = w;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        if (prev_v) held = ref_decode(prev_w);
        check_valid(out_valid, prev_v, "gap end");
        check_decoded(decoded, held, "gap end");
    endtask

    initial begin
        arst_n   = 1'b0;
        in_valid = 1'b0;
        inst     = '0;
        reset_checks();
        all_valid_numbers();
        immediate_formats();
        invalid_encodings();
        streaming();
        valid_gaps();
        $display("Decode tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #((test_cycles + 200) * 8);
        $display("Timeout: the tests did not finish within %0d cycles", test_cycles + 200);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/idu_pkg.sv
source/idu_funct_decode.sv
source/idu_opcode.sv
source/idu.sv
verif/idu_tb.sv

//--- Makefile
# Verilator build and run of the decode stage testbench

SIM = obj_dir/idu_tb_sim

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f filelist.f --top-module idu_tb \
		-Mdir obj_dir -o idu_tb_sim

# The run passes only when the log holds the pass line
run: build
	./$(SIM) | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

lint:
	verilator --lint-only -Wall -f filelist.f --top-module idu

clean:
	rm -rf obj_dir sim.log
